// File: logic/bp_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor sizing and tuning constants
// Table geometry, counter levels and field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Counter table geometry
`define BP_ENTRIES       16
`define BP_INDEX_WIDTH   4

// Counter levels, 0 and 1 not taken, 2 and 3 taken
`define BP_LEVELS        4
`define BP_COUNT_WIDTH   2
// Weakly not taken
`define BP_RESET_LEVEL   1

`define BP_PC_WIDTH      16
`define BP_RAND_WIDTH    8
// Saturating step when random byte below this, i.e. 64/256
`define BP_SAT_THRESHOLD 64

`endif

// File: logic/bp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor shared types
// Address, index, counter level, random byte, opcode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bp_defs.svh"

`default_nettype none

package bp_pkg;

  // Branch address as sent by the host
  typedef logic [`BP_PC_WIDTH-1:0] pc_t;

  // Table index after hashing
  typedef logic [`BP_INDEX_WIDTH-1:0] index_t;

  // Counter level, upper bit is the direction
  typedef logic [`BP_COUNT_WIDTH-1:0] count_t;

  // Random byte from the LFSR
  typedef logic [`BP_RAND_WIDTH-1:0] rand_t;

  // Request type
  typedef enum logic {
    OP_PREDICT = 1'b0,
    OP_TRAIN   = 1'b1
  } op_t;

endpackage

`default_nettype wire

// File: logic/probabilistic_saturating_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Probabilistic saturating counter
// Up/down counter whose steps into either extreme
// level only happen on a low random byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module probabilistic_saturating_counter #(
  parameter int LEVELS      = 4,
  parameter int RESET_LEVEL = 1,
  parameter int THRESHOLD   = 64
) (
  input  wire              clock,
  input  wire              resetn,
  input  wire              increment,
  input  wire              decrement,
  input  bp_pkg::rand_t    random,
  output bp_pkg::count_t   count
);

  // Level markers
  localparam bp_pkg::count_t LEVEL_MIN      = '0;
  localparam bp_pkg::count_t LEVEL_MIN_NEXT = bp_pkg::count_t'(1);
  localparam bp_pkg::count_t LEVEL_MAX      = bp_pkg::count_t'(LEVELS - 1);
  localparam bp_pkg::count_t LEVEL_MAX_PREV = bp_pkg::count_t'(LEVELS - 2);

  logic at_min;
  logic at_max;
  logic near_min;
  logic near_max;
  logic saturate_ok;

  assign at_min   = (count == LEVEL_MIN);
  assign at_max   = (count == LEVEL_MAX);
  assign near_min = (count == LEVEL_MIN_NEXT);
  assign near_max = (count == LEVEL_MAX_PREV);

  // Random draw allowing a step into an extreme
  assign saturate_ok = (random < THRESHOLD);

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      count <= bp_pkg::count_t'(RESET_LEVEL);
    end else if (increment) begin
      // Increment wins over decrement
      // Middle steps are unconditional
      if (!at_max && (!near_max || saturate_ok)) begin
        count <= count + 1'b1;
      end
    end else if (decrement) begin
      if (!at_min && (!near_min || saturate_ok)) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/lfsr_random_source.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running random source
// 16-bit Galois LFSR, low byte used as random number
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module lfsr_random_source (
  input  wire            clock,
  input  wire            resetn,
  output bp_pkg::rand_t  random
);

  // Taps 16, 14, 13, 11 as a right-shifting Galois mask
  localparam logic [15:0] TAP_MASK = 16'hB400;
  // Any non-zero value works, all-zero would lock up
  localparam logic [15:0] SEED     = 16'hACE1;

  logic [15:0] state;
  logic [15:0] state_next;

  // Shift right, fold the outgoing bit into the taps
  always_comb begin
    state_next = {1'b0, state[15:1]};
    if (state[0]) begin
      state_next = state_next ^ TAP_MASK;
    end
  end

  // Advances on every cycle regardless of traffic
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state <= SEED;
    end else begin
      state <= state_next;
    end
  end

  // Low byte to the counters
  assign random = state[7:0];

endmodule

`default_nettype wire

// File: logic/predictor_index_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Predictor index stage
// Four-phase req/ack front end, request register
// and address hash to a table index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bp_defs.svh"

`default_nettype none

module predictor_index_stage (
  input  wire             clock,
  input  wire             resetn,
  input  wire             req,
  input  bp_pkg::op_t     op,
  input  bp_pkg::pc_t     pc,
  input  wire             outcome,
  output logic            ack,
  output logic            s1_valid,
  output bp_pkg::op_t     s1_op,
  output bp_pkg::index_t  s1_index,
  output logic            s1_outcome
);

  // Low slice skips the two word-alignment bits
  localparam int LO_BASE = 2;
  // Next slice up is folded in
  localparam int HI_BASE = LO_BASE + `BP_INDEX_WIDTH;

  logic           accept;
  bp_pkg::index_t hashed_index;

  // New request: req high, previous handshake fully closed
  assign accept = req && !ack;

  // Bits 5:2 xor bits 9:6
  assign hashed_index = pc[LO_BASE +: `BP_INDEX_WIDTH] ^ pc[HI_BASE +: `BP_INDEX_WIDTH];

  // Handshake state
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      ack <= 1'b0;
    end else if (accept) begin
      // Phase 2, acknowledge at capture
      ack <= 1'b1;
    end else if (ack && !req) begin
      // Phase 4, release once host has dropped req
      ack <= 1'b0;
    end
  end

  // One pulse per accepted request
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= accept;
    end
  end

  // Request register, loaded on the capture edge only
  // Fields stay put until the next request
  always_ff @(posedge clock) begin
    if (accept) begin
      s1_op      <= op;
      s1_index   <= hashed_index;
      s1_outcome <= outcome;
    end
  end

endmodule

`default_nettype wire

// File: logic/counter_table_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counter table stage
// 16 probabilistic counters, training and prediction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bp_defs.svh"

`default_nettype none

module counter_table_stage (
  input  wire             clock,
  input  wire             resetn,
  input  wire             s1_valid,
  input  bp_pkg::op_t     s1_op,
  input  bp_pkg::index_t  s1_index,
  input  wire             s1_outcome,
  input  bp_pkg::rand_t   random,
  output logic            resp_valid,
  output logic            resp_taken,
  output bp_pkg::count_t  resp_count
);

  logic is_train;
  logic is_predict;

  // Per-entry strobes and levels
  logic [`BP_ENTRIES-1:0] increment;
  logic [`BP_ENTRIES-1:0] decrement;
  bp_pkg::count_t         levels [`BP_ENTRIES];

  // Addressed level, read straight off the table
  bp_pkg::count_t         read_level;

  // Item type qualified by the stage valid
  assign is_train   = s1_valid && (s1_op == bp_pkg::OP_TRAIN);
  assign is_predict = s1_valid && (s1_op == bp_pkg::OP_PREDICT);

  genvar i;
  generate
    for (i = 0; i < `BP_ENTRIES; i++) begin : g_entry
      logic selected;

      assign selected = (s1_index == bp_pkg::index_t'(i));

      // Taken trains up, not taken trains down, only the addressed entry
      assign increment[i] = is_train && selected && s1_outcome;
      assign decrement[i] = is_train && selected && !s1_outcome;

      probabilistic_saturating_counter #(
        .LEVELS      (`BP_LEVELS),
        .RESET_LEVEL (`BP_RESET_LEVEL),
        .THRESHOLD   (`BP_SAT_THRESHOLD)
      ) u_counter (
        .clock     (clock),
        .resetn    (resetn),
        .increment (increment[i]),
        .decrement (decrement[i]),
        .random    (random),
        .count     (levels[i])
      );
    end
  endgenerate

  // Level before this edge's update
  // A training item never shares the cycle with a prediction
  assign read_level = levels[s1_index];

  // Response strobe, one cycle per prediction
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= is_predict;
    end
  end

  // Response payload, held between predictions
  always_ff @(posedge clock) begin
    if (is_predict) begin
      resp_count <= read_level;
      // Upper bit set means level 2 or 3, taken
      resp_taken <= read_level[`BP_COUNT_WIDTH-1];
    end
  end

endmodule

`default_nettype wire

// File: logic/branch_predictor_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch direction predictor, top level
// LFSR, index stage and counter table stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module branch_predictor_top (
  input  wire             clock,
  input  wire             resetn,
  input  wire             req,
  input  bp_pkg::op_t     op,
  input  bp_pkg::pc_t     pc,
  input  wire             outcome,
  output logic            ack,
  output logic            resp_valid,
  output logic            resp_taken,
  output bp_pkg::count_t  resp_count
);

  // Stage one to stage two
  logic           s1_valid;
  bp_pkg::op_t    s1_op;
  bp_pkg::index_t s1_index;
  logic           s1_outcome;

  // Random byte, new every cycle
  bp_pkg::rand_t  random;

  lfsr_random_source u_lfsr (
    .clock  (clock),
    .resetn (resetn),
    .random (random)
  );

  // Host handshake and hashing
  predictor_index_stage u_index_stage (
    .clock      (clock),
    .resetn     (resetn),
    .req        (req),
    .op         (op),
    .pc         (pc),
    .outcome    (outcome),
    .ack        (ack),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .s1_index   (s1_index),
    .s1_outcome (s1_outcome)
  );

  // Counters, training and response
  counter_table_stage u_table_stage (
    .clock      (clock),
    .resetn     (resetn),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .s1_index   (s1_index),
    .s1_outcome (s1_outcome),
    .random     (random),
    .resp_valid (resp_valid),
    .resp_taken (resp_taken),
    .resp_count (resp_count)
  );

endmodule

`default_nettype wire

// File: tb/branch_predictor_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor protocol assertions
// Handshake and response rules bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module branch_predictor_props (
  input wire            clock,
  input wire            resetn,
  input wire            req,
  input wire            ack,
  input wire            resp_valid,
  input bp_pkg::count_t resp_count
);

  // Phase 2 only answers a raised request
  ack_rise_needs_req: assert property (
    @(posedge clock) disable iff (!resetn) $rose(ack) |-> $past(req)
  ) else $error("ack rose while req was low");

  // Phase 4 only after the host let go
  ack_fall_after_req: assert property (
    @(posedge clock) disable iff (!resetn) $fell(ack) |-> $past(!req)
  ) else $error("ack fell while req was still high");

  // Response is a single-cycle strobe
  resp_single_pulse: assert property (
    @(posedge clock) disable iff (!resetn) resp_valid |=> !resp_valid
  ) else $error("resp_valid held for two cycles");

  // Every response carries a defined level
  resp_count_known: assert property (
    @(posedge clock) disable iff (!resetn)
      resp_valid |-> !$isunknown(resp_count)
  ) else $error("resp_count unknown during a response");

endmodule

bind branch_predictor_top branch_predictor_props u_props (
  .clock      (clock),
  .resetn     (resetn),
  .req        (req),
  .ack        (ack),
  .resp_valid (resp_valid),
  .resp_count (resp_count)
);

`default_nettype wire

// File: tb/branch_predictor_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch predictor testbench
// File-driven four-phase requests, bounded counter model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "bp_defs.svh"

`default_nettype none

module branch_predictor_tb;

  localparam int CLOCK_PERIOD = 40;
  // Cycles allowed for either ack edge
  localparam int ACK_LIMIT    = 8;

  logic           clock;
  logic           resetn;
  logic           req;
  bp_pkg::op_t    op;
  bp_pkg::pc_t    pc;
  logic           outcome;
  logic           ack;
  logic           resp_valid;
  logic           resp_taken;
  bp_pkg::count_t resp_count;

  // Operations from the data file, repeats expanded
  bp_pkg::op_t    item_op [$];
  bp_pkg::pc_t    item_pc [$];
  logic           item_outcome [$];
  logic [7:0]     item_expect [$];

  // Lowest and highest level each counter could hold
  bp_pkg::count_t lo_bound [`BP_ENTRIES];
  bp_pkg::count_t hi_bound [`BP_ENTRIES];

  logic [31:0]    lcg_state;
  int             resp_seen;
  int             resp_wanted;
  logic           loaded;

  branch_predictor_top uut (
    .clock      (clock),
    .resetn     (resetn),
    .req        (req),
    .op         (op),
    .pc         (pc),
    .outcome    (outcome),
    .ack        (ack),
    .resp_valid (resp_valid),
    .resp_taken (resp_taken),
    .resp_count (resp_count)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_taken(input string name, input bit got, input bit want);
    if (got !== want)
      report_failure($sformatf("MISMATCH at time %0t: %s = %0b, expected %0b",
                               $time, name, got, want));
  endtask

  // Level must lie inside the model range
  task automatic check_count(input string name, input bp_pkg::count_t got,
                             input bp_pkg::count_t lo, input bp_pkg::count_t hi);
    if (got < lo || got > hi)
      report_failure($sformatf("MISMATCH at time %0t: %s = %0d, expected %0d to %0d",
                               $time, name, got, lo, hi));
  endtask

  // Bits 5:2 xor bits 9:6
  function automatic bp_pkg::index_t table_index(input bp_pkg::pc_t addr);
    return addr[5:2] ^ addr[9:6];
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Steps into 3 or 0 may or may not happen, so that bound waits
  task automatic model_train(input bp_pkg::index_t idx, input logic taken);
    if (taken) begin
      if (lo_bound[idx] < 2)
        lo_bound[idx] = lo_bound[idx] + 1'b1;
      if (hi_bound[idx] < 3)
        hi_bound[idx] = hi_bound[idx] + 1'b1;
    end else begin
      if (hi_bound[idx] > 1)
        hi_bound[idx] = hi_bound[idx] - 1'b1;
      if (lo_bound[idx] > 0)
        lo_bound[idx] = lo_bound[idx] - 1'b1;
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          fields;
    int          outc;
    int          repeat_n;
    string       line;
    logic [7:0]  op_char;
    logic [7:0]  expect_char;
    bp_pkg::pc_t addr;
    fd = $fopen("tb/branch_predictor_testdata.txt", "r");
    if (fd == 0)
      report_failure("Cannot open tb/branch_predictor_testdata.txt");
    while (!$feof(fd)) begin
      line = "";
      fields = 0;
      void'($fgets(line, fd));
      // Lines starting with # hold the column notes
      if (line.len() > 0 && line.getc(0) != "#")
        fields = $sscanf(line, "%s %h %d %s %d", op_char, addr, outc, expect_char, repeat_n);
      if (fields == 5) begin
        if (op_char != "P" && op_char != "T")
          report_failure("Unknown operation letter in the data file");
        for (int k = 0; k < repeat_n; k++) begin
          item_op.push_back(op_char == "T" ? bp_pkg::OP_TRAIN : bp_pkg::OP_PREDICT);
          item_pc.push_back(addr);
          item_outcome.push_back(outc[0]);
          item_expect.push_back(expect_char);
        end
      end
    end
    $fclose(fd);
  endtask

  // One full four-phase transfer plus its checks
  task automatic run_item(input int n);
    bp_pkg::index_t idx;
    int             waits;
    logic           known;
    logic           model_taken;
    idx = table_index(item_pc[n]);
    @(posedge clock);
    req <= 1'b1;
    op <= item_op[n];
    pc <= item_pc[n];
    outcome <= item_outcome[n];
    waits = 0;
    do begin
      @(negedge clock);
      waits++;
      if (waits > ACK_LIMIT)
        report_failure("No ack came back for a raised request");
    end while (ack !== 1'b1);
    // Response lands one edge after the ack edge
    @(posedge clock);
    req <= 1'b0;
    @(negedge clock);
    if (item_op[n] == bp_pkg::OP_PREDICT) begin
      resp_wanted++;
      if (resp_valid !== 1'b1)
        report_failure("No resp_valid two edges after the request was sampled");
      check_count("resp_count", resp_count, lo_bound[idx], hi_bound[idx]);
      known = (lo_bound[idx] >= 2) || (hi_bound[idx] < 2);
      model_taken = (lo_bound[idx] >= 2);
      if (item_expect[n] != "-") begin
        if (known && model_taken != (item_expect[n] == "1"))
          report_failure("Data file direction disagrees with the counter model");
        check_taken("resp_taken", resp_taken, item_expect[n] == "1");
      end else if (known) begin
        check_taken("resp_taken", resp_taken, model_taken);
      end
      // The observed level is the exact counter state from here on
      lo_bound[idx] = resp_count;
      hi_bound[idx] = resp_count;
    end else begin
      if (resp_valid !== 1'b0)
        report_failure("resp_valid was raised for a training request");
      model_train(idx, item_outcome[n]);
    end
    waits = 0;
    while (ack !== 1'b0) begin
      @(negedge clock);
      waits++;
      if (waits > ACK_LIMIT)
        report_failure("ack never dropped after req was released");
    end
  endtask

  // Counts every response strobe for the ordering check
  always @(negedge clock) begin
    if (resetn === 1'b1 && resp_valid === 1'b1)
      resp_seen++;
  end

  initial begin
    int limit;
    wait (loaded === 1'b1);
    limit = 12 * item_op.size() + 200;
    repeat (limit) @(posedge clock);
    report_failure("Watchdog timeout, the test sequence did not finish in time");
  end

  initial begin
    req = 1'b0;
    op = bp_pkg::OP_PREDICT;
    pc = '0;
    outcome = 1'b0;
    resetn = 1'b0;
    resp_seen = 0;
    resp_wanted = 0;
    loaded = 1'b0;
    lcg_state = 32'h19aef86d;
    for (int e = 0; e < `BP_ENTRIES; e++) begin
      lo_bound[e] = bp_pkg::count_t'(`BP_RESET_LEVEL);
      hi_bound[e] = bp_pkg::count_t'(`BP_RESET_LEVEL);
    end
    load_testdata();
    loaded = 1'b1;
    repeat (4) @(posedge clock);
    resetn <= 1'b1;
    for (int n = 0; n < item_op.size(); n++) begin
      run_item(n);
      // Zero to three idle cycles between requests
      lcg_state = lcg_next(lcg_state);
      repeat (lcg_state[31:30]) @(posedge clock);
    end
    repeat (3) @(negedge clock);
    if (resp_seen != resp_wanted) begin
      report_failure("Response count differs from the number of predictions");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/bp_pkg.sv
logic/probabilistic_saturating_counter.sv
logic/lfsr_random_source.sv
logic/predictor_index_stage.sv
logic/counter_table_stage.sv
logic/branch_predictor_top.sv
tb/branch_predictor_props.sv
tb/branch_predictor_tb.sv

// File: tb/branch_predictor_testdata.txt
# op pc outcome expect repeat; op P predict or T train, pc in hex
# expect is the predicted direction 0, 1 or - for don't care
P 0000 0 0 1
P 0004 0 0 1
P 0008 0 0 1
P 000C 0 0 1
P 0010 0 0 1
P 0014 0 0 1
P 0018 0 0 1
P 001C 0 0 1
P 0020 0 0 1
P 0024 0 0 1
P 0028 0 0 1
P 002C 0 0 1
P 0030 0 0 1
P 0034 0 0 1
P 0038 0 0 1
P 003C 0 0 1
T 0010 1 - 1
P 0010 0 1 1
T 0010 0 - 1
P 0010 0 0 1
T 0020 1 - 1
P 0220 0 0 1
P 0020 0 1 1
P 0244 0 1 1
T 0030 1 - 40
P 0030 0 1 1
T 0030 0 - 1
P 0030 0 1 1
T 0008 0 - 10
P 0008 0 0 1
T 0008 1 - 1
P 0008 0 - 1
